/* compile.f */
+incdir+src
src/long_div_pkg.sv
src/div_ctrl.sv
src/digit_counter.sv
src/operand_table.sv
src/digit_search.sv
src/long_div_u16_by_u8.sv
verif/long_div_asserts.sv
verif/tb_long_div.sv

/* Bender.yml */
package:
  name: long_div_u16_by_u8

sources:
  - include_dirs:
      - src
    files:
      - src/long_div_pkg.sv
      - src/div_ctrl.sv
      - src/digit_counter.sv
      - src/operand_table.sv
      - src/digit_search.sv
      - src/long_div_u16_by_u8.sv
  - target: test
    files:
      - verif/long_div_asserts.sv
      - verif/tb_long_div.sv

/* verif/tb_long_div.sv */
module tb_long_div import long_div_pkg::*;
();

	localparam logic [31:0] RNG_SEED = 32'h52c8_8bc9;
	localparam int NUM_EDGE = 7;
	localparam int NUM_ZERO = 4;
	localparam int NUM_RANDOM = 300;
	localparam int NUM_BUSY = 3;
	localparam int NUM_HOLD = 3;
	localparam int NUM_DIVISIONS = NUM_EDGE + NUM_ZERO + NUM_RANDOM + NUM_BUSY + NUM_HOLD;
	localparam int CYCLE_LIMIT = 20 * NUM_DIVISIONS + 200;

	logic clk;
	logic reset;
	logic start;
	div_cmd_t cmd;
	div_result_t result;
	logic data_valid;
	logic can_accept_cmd;

	logic [31:0] rng_state;
	int error_count;
	int check_count;
	int test_count;
	int cycle_count;

	long_div_u16_by_u8 i_dut
	(
		.clk(clk),
		.reset(reset),
		.start(start),
		.cmd(cmd),
		.result(result),
		.data_valid(data_valid),
		.can_accept_cmd(can_accept_cmd)
	);

	// controller ports carry the top-level control timing
	bind div_ctrl long_div_asserts i_long_div_asserts
	(
		.clk(clk),
		.reset(reset),
		.start(start),
		.state(state),
		.data_valid(data_valid),
		.can_accept_cmd(can_accept_cmd)
	);

	initial
	begin
		clk = 1'b0;
	end

	always #5 clk = ~clk;

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT)
		begin
			$display("timeout: divider did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function logic [31:0] next_random();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	// unsigned division where x / 0 gives 0 remainder 0
	function automatic quotient_t model_quotient(input dividend_t a, input divisor_t b);
		if (b == '0)
		begin
			return '0;
		end
		return quotient_t'(a / b);
	endfunction

	function automatic remainder_t model_remainder(input dividend_t a, input divisor_t b);
		if (b == '0)
		begin
			return '0;
		end
		return remainder_t'(a % b);
	endfunction

	task automatic compare_field(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		check_count++;
		if (got !== expected)
		begin
			error_count++;
			$display("ERROR at %0t: %s got 0x%0h, expected 0x%0h", $time, name, got, expected);
		end
	endtask

	// all stimulus and sampling one unit after the rising edge
	task automatic wait_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic report_test(input string name, input int errors_at_start);
		test_count++;
		$display("test %-14s done, %0d errors", name, error_count - errors_at_start);
	endtask

	task automatic run_division(input div_cmd_t c, input int busy_starts);
		int latency;
		int pulses_left;
		latency = 0;
		pulses_left = busy_starts;
		while (!can_accept_cmd)
		begin
			wait_cycle();
		end
		start = 1'b1;
		cmd = c;
		wait_cycle();
		start = 1'b0;
		compare_field("data_valid after start", data_valid, 1'b0);
		while (!data_valid)
		begin
			if (pulses_left > 0)
			begin
				// different operands that must not disturb the running division
				start = 1'b1;
				cmd = c ^ (div_cmd_t'(next_random()) | div_cmd_t'(1));
				pulses_left--;
			end
			else
			begin
				start = 1'b0;
			end
			wait_cycle();
			latency++;
		end
		start = 1'b0;
		compare_field("data_valid latency", latency, 4);
		compare_field("can_accept_cmd", can_accept_cmd, 1'b1);
		compare_field("result.quotient", result.quotient, model_quotient(c.dividend, c.divisor));
		compare_field("result.remainder", result.remainder,
			model_remainder(c.dividend, c.divisor));
	endtask

	function automatic div_cmd_t make_cmd(input dividend_t a, input divisor_t b);
		div_cmd_t c;
		c.dividend = a;
		c.divisor = b;
		return c;
	endfunction

	function div_cmd_t random_cmd();
		logic [31:0] r;
		r = next_random();
		return make_cmd(r[31:16], r[7:0]);
	endfunction

	initial
	begin
		int errors_at_start;
		int idle_cycles;
		div_cmd_t c;

		rng_state = RNG_SEED;
		error_count = 0;
		check_count = 0;
		test_count = 0;
		cycle_count = 0;
		reset = 1'b1;
		start = 1'b0;
		cmd = '0;
		repeat (10) @(posedge clk);
		#1;
		reset = 1'b0;

		errors_at_start = error_count;
		compare_field("data_valid", data_valid, 1'b0);
		compare_field("can_accept_cmd", can_accept_cmd, 1'b1);
		compare_field("result", result, '0);
		report_test("reset", errors_at_start);

		errors_at_start = error_count;
		run_division(make_cmd(16'h1234, 8'd1), 0);
		run_division(make_cmd(16'hffff, 8'd1), 0);
		run_division(make_cmd(16'hffff, 8'd255), 0);
		run_division(make_cmd(16'h1234, 8'd255), 0);
		run_division(make_cmd(16'h0000, 8'd7), 0);
		run_division(make_cmd(16'hffff, 8'd3), 0);
		run_division(make_cmd(16'd5, 8'd200), 0);
		report_test("edge operands", errors_at_start);

		errors_at_start = error_count;
		run_division(make_cmd(16'h0000, 8'd0), 0);
		run_division(make_cmd(16'h0001, 8'd0), 0);
		run_division(make_cmd(16'habcd, 8'd0), 0);
		run_division(make_cmd(16'hffff, 8'd0), 0);
		report_test("divide by zero", errors_at_start);

		errors_at_start = error_count;
		repeat (NUM_RANDOM)
		begin
			run_division(random_cmd(), 0);
		end
		report_test("random", errors_at_start);

		errors_at_start = error_count;
		repeat (NUM_BUSY)
		begin
			run_division(random_cmd(), 3);
		end
		report_test("busy starts", errors_at_start);

		errors_at_start = error_count;
		repeat (NUM_HOLD)
		begin
			c = random_cmd();
			run_division(c, 0);
			idle_cycles = 1 + int'(next_random() % 12);
			repeat (idle_cycles)
			begin
				wait_cycle();
				compare_field("data_valid held", data_valid, 1'b1);
				compare_field("result.quotient held", result.quotient,
					model_quotient(c.dividend, c.divisor));
				compare_field("result.remainder held", result.remainder,
					model_remainder(c.dividend, c.divisor));
			end
		end
		report_test("result hold", errors_at_start);

		// failed bound assertions
		error_count += i_dut.i_div_ctrl.i_long_div_asserts.failure_count;

		$display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
		if (error_count == 0)
		begin
			$display("Simulation finished: PASS");
		end
		else
		begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

/* verif/long_div_asserts.sv */
module long_div_asserts import long_div_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic start,
	input div_state_t state,
	input logic data_valid,
	input logic can_accept_cmd
);

	logic accepted;
	int failure_count = 0;

	// a start only takes effect while the divider can take it
	assign accepted = start && can_accept_cmd;

	// an idle divider either holds a result or is ready for one
	idle_levels: assert property (@(posedge clk) disable iff (reset)
		(state == ST_IDLE) |-> (data_valid || can_accept_cmd))
		else
		begin
			failure_count++;
			$error("idle with both data_valid and can_accept_cmd low");
		end

	// ready again after four digit steps
	accept_latency: assert property (@(posedge clk) disable iff (reset)
		accepted |=> (!can_accept_cmd [*4]) ##1 can_accept_cmd)
		else
		begin
			failure_count++;
			$error("can_accept_cmd did not return four cycles after an accepted start");
		end

	// no stale result during E1 to E4
	valid_dropped: assert property (@(posedge clk) disable iff (reset)
		accepted |=> (!data_valid [*4]))
		else
		begin
			failure_count++;
			$error("data_valid high while a division is running");
		end

endmodule

/* src/long_div_u16_by_u8.sv */
module long_div_u16_by_u8 import long_div_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic start,
	input div_cmd_t cmd,
	output div_result_t result,
	output logic data_valid,
	output logic can_accept_cmd
);

	logic load;
	logic step;
	logic last_digit;
	digit_idx_t digit_idx;
	multiple_table_t multiples;
	dividend_t dividend;

	// idle/working sequencing and the handshake levels
	div_ctrl i_div_ctrl
	(
		.clk(clk),
		.reset(reset),
		.start(start),
		.last_digit(last_digit),
		.load(load),
		.step(step),
		.data_valid(data_valid),
		.can_accept_cmd(can_accept_cmd)
	);

	// which quotient digit is being resolved
	digit_counter i_digit_counter
	(
		.clk(clk),
		.reset(reset),
		.load(load),
		.step(step),
		.digit_idx(digit_idx),
		.last_digit(last_digit)
	);

	// captured operands and divisor multiples
	operand_table i_operand_table
	(
		.clk(clk),
		.load(load),
		.cmd(cmd),
		.multiples(multiples),
		.dividend(dividend)
	);

	// per-digit search, subtract and quotient assembly
	digit_search i_digit_search
	(
		.clk(clk),
		.reset(reset),
		.load(load),
		.step(step),
		.digit_idx(digit_idx),
		.multiples(multiples),
		.dividend(dividend),
		.result(result)
	);

endmodule

/* src/digit_search.sv */
`include "long_div_macros.svh"

module digit_search import long_div_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic load,
	input logic step,
	input digit_idx_t digit_idx,
	input multiple_table_t multiples,
	input dividend_t dividend,
	output div_result_t result
);

	remainder_t remainder_q;
	quotient_t quotient_q;

	digit_t nibble;
	partial_t partial;
	partial_t difference;

	// candidate digit after each search level
	digit_t cand_l3;
	digit_t cand_l2;
	digit_t cand_l1;
	digit_t digit;

	// next dividend nibble, most significant first
	assign nibble = dividend[digit_idx * `LONG_DIV_RADIX_BITS +: `LONG_DIV_RADIX_BITS];

	// bring the nibble down next to the running remainder
	assign partial = {remainder_q, nibble};

	// binary search for the largest k with k * divisor <= partial
	always_comb
	begin
		// level 1 splits 0..7 from 8..15
		if (multiples[8] <= partial)
		begin
			cand_l3 = digit_t'(8);
		end
		else
		begin
			cand_l3 = digit_t'(0);
		end

		// level 2 tests bit 2
		if (multiples[cand_l3 | digit_t'(4)] <= partial)
		begin
			cand_l2 = cand_l3 | digit_t'(4);
		end
		else
		begin
			cand_l2 = cand_l3;
		end

		// level 3 tests bit 1
		if (multiples[cand_l2 | digit_t'(2)] <= partial)
		begin
			cand_l1 = cand_l2 | digit_t'(2);
		end
		else
		begin
			cand_l1 = cand_l2;
		end

		// last level settles bit 0
		if (multiples[cand_l1 | digit_t'(1)] <= partial)
		begin
			digit = cand_l1 | digit_t'(1);
		end
		else
		begin
			digit = cand_l1;
		end
	end

	// always below the divisor, so the upper bits are zero
	assign difference = partial - multiples[digit];

	always_ff @(posedge clk)
	begin
		if (reset || load)
		begin
			remainder_q <= '0;
			quotient_q <= '0;
		end
		else if (step)
		begin
			remainder_q <= difference[7:0];
			quotient_q[digit_idx * `LONG_DIV_RADIX_BITS +: `LONG_DIV_RADIX_BITS] <= digit;
		end
	end

	// stays put between divisions
	assign result.quotient = quotient_q;
	assign result.remainder = remainder_q;

endmodule

/* src/operand_table.sv */
`include "long_div_macros.svh"

module operand_table import long_div_pkg::*;
(
	input logic clk,
	input logic load,
	input div_cmd_t cmd,
	output multiple_table_t multiples,
	output dividend_t dividend
);

	logic divisor_is_zero;
	divisor_t divisor_eff;
	dividend_t dividend_eff;
	multiple_table_t multiples_next;

	assign divisor_is_zero = (cmd.divisor == '0);

	// x / 0 runs as 0 / 1, giving quotient 0 and remainder 0
	assign divisor_eff = divisor_is_zero ? divisor_t'(1) : cmd.divisor;
	assign dividend_eff = divisor_is_zero ? '0 : cmd.dividend;

	// table of divisor times 0 .. 15
	always_comb
	begin
		for (int k = 0; k < `LONG_DIV_NUM_MULTIPLES; k++)
		begin
			multiples_next[k] = multiple_t'(divisor_eff) * multiple_t'(k);
		end
	end

	// held for the whole division, only rewritten on an accepted start
	always_ff @(posedge clk)
	begin
		if (load)
		begin
			dividend <= dividend_eff;
			multiples <= multiples_next;
		end
	end

endmodule

/* src/digit_counter.sv */
`include "long_div_macros.svh"

module digit_counter import long_div_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic load,
	input logic step,
	output digit_idx_t digit_idx,
	output logic last_digit
);

	// most significant digit goes first
	localparam digit_idx_t TOP_DIGIT = digit_idx_t'(`LONG_DIV_NUM_DIGITS - 1);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			digit_idx <= '0;
		end
		else if (load)
		begin
			digit_idx <= TOP_DIGIT;
		end
		else if (step)
		begin
			// wraps after digit 0, harmless since the FSM is idle then
			digit_idx <= digit_idx - digit_idx_t'(1);
		end
	end

	// low nibble position ends the division
	assign last_digit = (digit_idx == '0);

endmodule

/* src/div_ctrl.sv */
module div_ctrl import long_div_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic start,
	input logic last_digit,
	output logic load,
	output logic step,
	output logic data_valid,
	output logic can_accept_cmd
);

	div_state_t state;
	div_state_t state_next;

	// a start only counts while idle, busy starts fall through
	assign load = start && (state == ST_IDLE);

	// one digit resolved per working cycle
	assign step = (state == ST_WORKING);

	always_comb
	begin
		state_next = state;
		case (state)
			ST_IDLE:
			begin
				if (start)
				begin
					state_next = ST_WORKING;
				end
			end

			ST_WORKING:
			begin
				// leave after the least significant digit
				if (last_digit)
				begin
					state_next = ST_IDLE;
				end
			end

			default:
			begin
				state_next = ST_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= ST_IDLE;
			data_valid <= 1'b0;
			can_accept_cmd <= 1'b1;
		end
		else
		begin
			state <= state_next;

			if (load)
			begin
				// old result is stale from here on
				data_valid <= 1'b0;
				can_accept_cmd <= 1'b0;
			end
			else if (step && last_digit)
			begin
				data_valid <= 1'b1;
				can_accept_cmd <= 1'b1;
			end
		end
	end

endmodule

/* src/long_div_pkg.sv */
`include "long_div_macros.svh"

package long_div_pkg;

	// operand and result widths
	typedef logic [`LONG_DIV_RADIX_BITS*`LONG_DIV_NUM_DIGITS-1:0] dividend_t;
	typedef logic [7:0] divisor_t;
	typedef logic [`LONG_DIV_RADIX_BITS*`LONG_DIV_NUM_DIGITS-1:0] quotient_t;
	typedef logic [7:0] remainder_t;

	// remainder below 256, shifted up one digit, plus a nibble
	typedef logic [11:0] partial_t;

	// at most 255 * 15
	typedef logic [11:0] multiple_t;

	// quotient digit or dividend nibble
	typedef logic [`LONG_DIV_RADIX_BITS-1:0] digit_t;

	// digit position, highest value is the most significant digit
	typedef logic [$clog2(`LONG_DIV_NUM_DIGITS)-1:0] digit_idx_t;

	// entry k holds k times the divisor
	typedef multiple_t [`LONG_DIV_NUM_MULTIPLES-1:0] multiple_table_t;

	typedef struct packed
	{
		dividend_t dividend;
		divisor_t divisor;
	} div_cmd_t;

	typedef struct packed
	{
		quotient_t quotient;
		remainder_t remainder;
	} div_result_t;

	typedef enum logic
	{
		ST_IDLE,
		ST_WORKING
	} div_state_t;

endpackage

/* src/long_div_macros.svh */
`ifndef LONG_DIV_MACROS_SVH
`define LONG_DIV_MACROS_SVH

// quotient digit size, one hex digit per step
`define LONG_DIV_RADIX_BITS 4

// 16-bit dividend split into hex digits
`define LONG_DIV_NUM_DIGITS 4

// one entry per possible digit value
`define LONG_DIV_NUM_MULTIPLES 16

// derived relations, for reference
//   dividend and quotient width = radix bits * digit count
//   multiple table covers digit values 0 .. 2**radix bits - 1
//   partial remainder width = divisor width + radix bits

`endif
